// ==== cacheArray.sv ====
`timescale 1ns/1ps

module cacheArray #(
    parameter int addrBits = cachePkg::defAddrBits,
    parameter int idBits   = cachePkg::defIdBits
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [idBits-1:0]   id,
    input  logic                ce,
    input  logic                we,
    input  logic [addrBits-1:0] addr,
    input  cachePkg::cacheWord  wrData,
    output cachePkg::cacheWord  rdData
);

    import cachePkg::*;

    localparam int numBanks = 2 ** idBits;

    cacheWord          bankRdData [numBanks];
    logic [idBits-1:0] idPipe [readLatency];

    for (genvar b = 0; b < numBanks; b++) begin : gBank
        logic bankCe;

        // Only the addressed bank sees an active enable
        assign bankCe = ce || (id != idBits'(b));

        cacheBank #(
            .addrBits(addrBits)
        ) i_cacheBank (
            .clk   (clk),
            .ce    (bankCe),
            .we    (we),
            .addr  (addr),
            .wrData(wrData),
            .rdData(bankRdData[b])
        );
    end

    // Bank ID follows each read so the mux lines up with the returning word
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < readLatency; i++) begin
                idPipe[i] <= '0;
            end
        end else begin
            idPipe[0] <= id;
            for (int i = 1; i < readLatency; i++) begin
                idPipe[i] <= idPipe[i-1];
            end
        end
    end

    assign rdData = bankRdData[idPipe[readLatency-1]];

endmodule

// ==== cacheBank.sv ====
`timescale 1ns/1ps

module cacheBank #(
    parameter int addrBits = cachePkg::defAddrBits
) (
    input  logic                clk,
    input  logic                ce,
    input  logic                we,
    input  logic [addrBits-1:0] addr,
    input  cachePkg::cacheWord  wrData,
    output cachePkg::cacheWord  rdData
);

    import cachePkg::*;

    localparam int depth = 2 ** addrBits;

    cacheWord            mem [depth];
    logic [addrBits-1:0] rdAddr;
    logic                wrEn;
    logic                rdEn;

    // Both enables are active low
    assign wrEn = !ce && !we;
    assign rdEn = !ce && we;

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[addr] <= wrData;
        end
    end

    // First read stage holds the address of the last read
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdAddr <= addr;
        end
    end

    // Second stage registers the word out
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];
    end

endmodule

// ==== cacheInterface.sv ====
`timescale 1ns/1ps

module cacheInterface #(
    parameter int addrBits = cachePkg::defAddrBits,
    parameter int lenBits  = cachePkg::defLenBits,
    parameter int idBits   = cachePkg::defIdBits,
    parameter int lineBits = cachePkg::defLineBits
) (
    input  logic                clk,
    input  logic                rst,

    input  logic                start,
    input  logic                write,
    input  logic [idBits-1:0]   bankId,
    input  logic [lenBits-1:0]  len,
    input  logic [addrBits-1:0] addr,
    output logic                busy,

    input  logic                strobe,
    input  cachePkg::cacheWord  wrData,
    output logic                rdValid,
    output cachePkg::cacheWord  rdData,

    output logic [idBits-1:0]   memId,
    output logic                memCe,
    output logic                memWe,
    output logic [addrBits-1:0] memAddr,
    output cachePkg::cacheWord  memWrData,
    input  cachePkg::cacheWord  memRdData
);

    import cachePkg::*;

    // Transfer state
    logic                active;
    logic                isWrite;
    logic [idBits-1:0]   curId;
    logic [lenBits-1:0]  lenCnt;
    logic [addrBits-1:0] addrCnt;

    // One bit per outstanding array read, oldest at the top
    logic [readLatency-1:0] reqPipe;

    // Two-entry skid buffer for words that arrive ahead of a pull
    cacheWord   skidBuf [2];
    logic [1:0] bufCnt;
    logic       insIdx;
    logic       outIdx;

    logic [2:0] pendCnt;
    logic       accept;
    logic       wrStep;
    logic       pull;
    logic       fromBuf;
    logic       issue;
    logic       arrive;
    logic       capture;
    logic       lastPull;
    logic       advance;

    // Buffered words plus reads still in flight
    always_comb begin
        pendCnt = {1'b0, bufCnt};
        for (int i = 0; i < readLatency; i++) begin
            pendCnt = pendCnt + {2'b00, reqPipe[i]};
        end
    end

    assign accept  = start && !active;
    assign wrStep  = active && isWrite && strobe;
    assign pull    = active && !isWrite && strobe;
    assign fromBuf = pull && (bufCnt != 2'd0);

    // Prefetch while words remain and there is room, or a pull frees a slot
    assign issue = active && !isWrite && (lenCnt != '0) && ((pendCnt < 3'd2) || pull);

    assign arrive = reqPipe[readLatency-1];

    // An arriving word bypasses the buffer only when a pull takes it directly
    assign capture = arrive && (!pull || fromBuf);

    assign lastPull = pull && (lenCnt == '0) && (pendCnt == 3'd1);
    assign advance  = wrStep || issue;

    assign busy    = active;
    assign rdValid = pull;
    assign rdData  = fromBuf ? skidBuf[outIdx] : memRdData;

    assign memId     = curId;
    assign memCe     = !advance;
    assign memWe     = !wrStep;
    assign memAddr   = addrCnt;
    assign memWrData = wrData;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active  <= 1'b0;
            isWrite <= 1'b0;
            curId   <= '0;
            lenCnt  <= '0;
            addrCnt <= '0;
        end else if (accept) begin
            active  <= 1'b1;
            isWrite <= write;
            curId   <= bankId;
            lenCnt  <= len;
            addrCnt <= addr;
        end else if (active) begin
            if (advance) begin
                lenCnt <= lenCnt - 1'b1;
                // Offset wraps inside the line, line bits stay put
                addrCnt[lineBits-1:0] <= addrCnt[lineBits-1:0] + 1'b1;
            end
            if ((wrStep && (lenCnt == lenBits'(1))) || lastPull) begin
                active <= 1'b0;
            end
        end
    end

    // Read-side bookkeeping
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reqPipe <= '0;
            bufCnt  <= 2'd0;
            insIdx  <= 1'b0;
            outIdx  <= 1'b0;
        end else if (accept) begin
            reqPipe <= '0;
            bufCnt  <= 2'd0;
            insIdx  <= 1'b0;
            outIdx  <= 1'b0;
        end else begin
            reqPipe <= {reqPipe[readLatency-2:0], issue};
            bufCnt  <= bufCnt + {1'b0, capture} - {1'b0, fromBuf};
            if (capture) begin
                insIdx <= !insIdx;
            end
            if (fromBuf) begin
                outIdx <= !outIdx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            skidBuf[insIdx] <= memRdData;
        end
    end

endmodule

// ==== cachePkg.sv ====
package cachePkg;

    // Data word on the stream and array paths
    typedef logic [31:0] cacheWord;

    // Word address width inside one bank
    localparam int defAddrBits = 10;

    // Transfer length counter width
    localparam int defLenBits = 8;

    // Bank select width, bank count is a power of two
    localparam int defIdBits = 1;

    // Low address bits forming the word offset within a line (8-word lines)
    localparam int defLineBits = 3;

    // Cycles from an array read request to its returning data
    localparam int readLatency = 2;

endpackage

// ==== cacheStreamTop.sv ====
`timescale 1ns/1ps

module cacheStreamTop #(
    parameter int addrBits = cachePkg::defAddrBits,
    parameter int lenBits  = cachePkg::defLenBits,
    parameter int idBits   = cachePkg::defIdBits,
    parameter int lineBits = cachePkg::defLineBits
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                write,
    input  logic [idBits-1:0]   bankId,
    input  logic [lenBits-1:0]  len,
    input  logic [addrBits-1:0] addr,
    output logic                busy,
    input  logic                strobe,
    input  cachePkg::cacheWord  wrData,
    output logic                rdValid,
    output cachePkg::cacheWord  rdData
);

    import cachePkg::*;

    // Front end to array
    logic [idBits-1:0]   memId;
    logic                memCe;
    logic                memWe;
    logic [addrBits-1:0] memAddr;
    cacheWord            memWrData;
    cacheWord            memRdData;

    cacheInterface #(
        .addrBits(addrBits),
        .lenBits (lenBits),
        .idBits  (idBits),
        .lineBits(lineBits)
    ) i_cacheInterface (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .write    (write),
        .bankId   (bankId),
        .len      (len),
        .addr     (addr),
        .busy     (busy),
        .strobe   (strobe),
        .wrData   (wrData),
        .rdValid  (rdValid),
        .rdData   (rdData),
        .memId    (memId),
        .memCe    (memCe),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memWrData(memWrData),
        .memRdData(memRdData)
    );

    cacheArray #(
        .addrBits(addrBits),
        .idBits  (idBits)
    ) i_cacheArray (
        .clk   (clk),
        .rst   (rst),
        .id    (memId),
        .ce    (memCe),
        .we    (memWe),
        .addr  (memAddr),
        .wrData(memWrData),
        .rdData(memRdData)
    );

endmodule

// ==== cacheStream_asserts.sv ====
`timescale 1ns/1ps

module cacheStreamAsserts (
    input logic clk,
    input logic rst,
    input logic start,
    input logic write,
    input logic busy,
    input logic strobe,
    input logic rdValid,
    input logic memCe
);

    logic readXfer;
    int   idleValidFails = 0;
    int   idleCeFails    = 0;
    int   echoFails      = 0;
    int   writeValidFails = 0;
    int   assertFails;

    assign assertFails = idleValidFails + idleCeFails + echoFails + writeValidFails;

    // Direction of the transfer in flight
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            readXfer <= 1'b0;
        end else if (start && !busy) begin
            readXfer <= !write;
        end
    end

    rdValidWhileBusy: assert property (@(posedge clk) disable iff (rst) rdValid |-> busy)
        else begin
            $error("rdValid high while idle");
            idleValidFails++;
        end

    ceHighWhenIdle: assert property (@(posedge clk) disable iff (rst) !busy |-> memCe)
        else begin
            $error("array enabled while idle");
            idleCeFails++;
        end

    // Every pull of a read is answered in its own cycle
    pullEcho: assert property (@(posedge clk) disable iff (rst)
        (busy && readXfer) |-> (rdValid == strobe))
        else begin
            $error("rdValid differs from strobe during a read");
            echoFails++;
        end

    noValidOnWrite: assert property (@(posedge clk) disable iff (rst)
        (busy && !readXfer) |-> !rdValid)
        else begin
            $error("rdValid high during a write");
            writeValidFails++;
        end

endmodule

bind cacheStreamTop cacheStreamAsserts i_cacheStreamAsserts (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .write  (write),
    .busy   (busy),
    .strobe (strobe),
    .rdValid(rdValid),
    .memCe  (memCe)
);

// ==== flist.f ====
cachePkg.sv
cacheBank.sv
cacheArray.sv
cacheInterface.sv
cacheStreamTop.sv
cacheStream_asserts.sv
tbCacheStream.sv

// ==== tbCacheStream.sv ====
`timescale 1ns/1ps

module tbCacheStream;

    import cachePkg::*;

    localparam int numBanks = 2 ** defIdBits;
    localparam int depth    = 2 ** defAddrBits;
    localparam int lineMask = (1 << defLineBits) - 1;

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic                   write;
    logic [defIdBits-1:0]   bankId;
    logic [defLenBits-1:0]  len;
    logic [defAddrBits-1:0] addr;
    logic                   busy;
    logic                   strobe;
    cacheWord               wrData;
    logic                   rdValid;
    cacheWord               rdData;

    // Expected contents of every bank
    cacheWord    model [numBanks][depth];
    logic [31:0] rngState;
    int          errCount;
    int          testCount;
    int          failCount;

    cacheStreamTop i_cacheStreamTop (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .write  (write),
        .bankId (bankId),
        .len    (len),
        .addr   (addr),
        .busy   (busy),
        .strobe (strobe),
        .wrData (wrData),
        .rdValid(rdValid),
        .rdData (rdData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Offset steps inside the line, the line bits stay put
    function automatic int nextAddr(input int a);
        return (a & ~lineMask) | ((a + 1) & lineMask);
    endfunction

    // Worst case for one transfer including its start
    function automatic int burstCycles(input int n, input int maxGap);
        return n * (maxGap + 1) + 8;
    endfunction

    task automatic reportTest(input string name, input int errsBefore);
        testCount++;
        if (errCount == errsBefore) begin
            $display("%s: ok", name);
        end else begin
            failCount++;
            $display("%s: FAILED with %0d errors", name, errCount - errsBefore);
        end
    endtask

    task automatic startXfer(input logic wr, input int id, input int n, input int a);
        @(negedge clk);
        start  = 1'b1;
        write  = wr;
        bankId = defIdBits'(id);
        len    = defLenBits'(n);
        addr   = defAddrBits'(a);
        @(posedge clk);
        @(negedge clk);
        start = 1'b0;
        if (busy !== 1'b1) begin
            $display("Error: busy expected 0x1 got 0x%h after start", busy);
            errCount++;
        end
    endtask

    // Bit i of gapMask puts one idle cycle before word i
    task automatic writeBurst(input int id, input int n, input int a, input logic [31:0] gapMask);
        int       cur;
        cacheWord data;
        cur = a;
        for (int i = 0; i < n; i++) begin
            if (gapMask[i % 32]) begin
                strobe = 1'b0;
                @(negedge clk);
            end
            rngState = xorshift(rngState);
            data     = rngState;
            wrData   = data;
            strobe   = 1'b1;
            @(posedge clk);
            if (busy !== 1'b1) begin
                $display("Error: busy expected 0x1 got 0x%h at write word %0d", busy, i);
                errCount++;
            end
            model[id][cur] = data;
            cur = nextAddr(cur);
            @(negedge clk);
            strobe = 1'b0;
        end
        if (busy !== 1'b0) begin
            $display("Error: busy expected 0x0 got 0x%h after last write", busy);
            errCount++;
        end
    endtask

    task automatic readBurst(input int id, input int n, input int a, input int maxGap);
        int cur;
        int pulls;
        int valids;
        int gap;
        cur    = a;
        pulls  = 0;
        valids = 0;
        // First pull no earlier than the third busy cycle
        repeat (readLatency) @(negedge clk);
        while (pulls < n) begin
            gap = 0;
            if (maxGap > 0) begin
                rngState = xorshift(rngState);
                gap = int'(rngState % (maxGap + 1));
            end
            strobe = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                if (rdValid === 1'b1) begin
                    valids++;
                end
                @(negedge clk);
            end
            strobe = 1'b1;
            @(posedge clk);
            if (rdValid === 1'b1) begin
                valids++;
            end
            if (rdValid !== 1'b1) begin
                $display("Error: rdValid expected 0x1 got 0x%h on pull %0d", rdValid, pulls);
                errCount++;
            end
            if (rdData !== model[id][cur]) begin
                $display("Error: rdData bank %0d addr 0x%03h expected 0x%08h got 0x%08h",
                         id, cur, model[id][cur], rdData);
                errCount++;
            end
            if (busy !== 1'b1) begin
                $display("Error: busy expected 0x1 got 0x%h on pull %0d", busy, pulls);
                errCount++;
            end
            pulls++;
            cur = nextAddr(cur);
            @(negedge clk);
            strobe = 1'b0;
        end
        if (busy !== 1'b0) begin
            $display("Error: busy expected 0x0 got 0x%h after last pull", busy);
            errCount++;
        end
        if (valids != n) begin
            $display("rdValid pulsed %0d times for a read of %0d words", valids, n);
            errCount++;
        end
    endtask

    task automatic testReset;
        int errs;
        errs = errCount;
        rst  = 1'b1;
        repeat (3) begin
            @(negedge clk);
            if (busy !== 1'b0 || rdValid !== 1'b0) begin
                $display("Error: busy/rdValid expected 0x0/0x0 got 0x%h/0x%h in reset",
                         busy, rdValid);
                errCount++;
            end
        end
        rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            if (busy !== 1'b0 || rdValid !== 1'b0) begin
                $display("Error: busy/rdValid expected 0x0/0x0 got 0x%h/0x%h after reset",
                         busy, rdValid);
                errCount++;
            end
        end
        reportTest("reset state", errs);
    endtask

    task automatic testWriteRead;
        int          errs;
        logic [31:0] gapMask;
        errs     = errCount;
        rngState = xorshift(rngState);
        gapMask  = rngState;
        startXfer(1'b1, 0, 8, 'h010);
        writeBurst(0, 8, 'h010, gapMask);
        startXfer(1'b0, 0, 8, 'h010);
        readBurst(0, 8, 'h010, 0);
        reportTest("write then read back", errs);
    endtask

    task automatic testLineWrap;
        int errs;
        errs = errCount;
        startXfer(1'b1, 0, 8, 'h040);
        writeBurst(0, 8, 'h040, 32'h0);
        startXfer(1'b1, 0, 8, 'h048);
        writeBurst(0, 8, 'h048, 32'h0);
        // Offsets 5, 6, 7 then 0 to 4 of line 0x40
        startXfer(1'b1, 0, 8, 'h045);
        writeBurst(0, 8, 'h045, 32'h0);
        startXfer(1'b0, 0, 8, 'h040);
        readBurst(0, 8, 'h040, 0);
        startXfer(1'b0, 0, 8, 'h048);
        readBurst(0, 8, 'h048, 0);
        reportTest("line wrap", errs);
    endtask

    task automatic testBanks;
        int errs;
        errs = errCount;
        startXfer(1'b1, 0, 8, 'h020);
        writeBurst(0, 8, 'h020, 32'h0);
        startXfer(1'b1, 1, 8, 'h020);
        writeBurst(1, 8, 'h020, 32'h0);
        startXfer(1'b0, 0, 8, 'h020);
        readBurst(0, 8, 'h020, 0);
        startXfer(1'b0, 1, 8, 'h020);
        readBurst(1, 8, 'h020, 0);
        reportTest("bank independence", errs);
    endtask

    task automatic testBackPressure;
        int errs;
        errs = errCount;
        startXfer(1'b1, 0, 16, 'h030);
        writeBurst(0, 16, 'h030, 32'h0);
        startXfer(1'b0, 0, 16, 'h030);
        readBurst(0, 16, 'h030, 8);
        reportTest("read back-pressure", errs);
    endtask

    task automatic testIgnoredStart;
        int errs;
        errs = errCount;
        startXfer(1'b1, 1, 4, 'h100);
        writeBurst(1, 4, 'h100, 32'h0);
        startXfer(1'b1, 0, 6, 'h080);
        // Second start lands while the first transfer runs
        start  = 1'b1;
        write  = 1'b1;
        bankId = defIdBits'(1);
        len    = defLenBits'(2);
        addr   = defAddrBits'('h100);
        @(posedge clk);
        @(negedge clk);
        start = 1'b0;
        if (busy !== 1'b1) begin
            $display("Error: busy expected 0x1 got 0x%h after second start", busy);
            errCount++;
        end
        writeBurst(0, 6, 'h080, 32'h0);
        startXfer(1'b0, 0, 6, 'h080);
        readBurst(0, 6, 'h080, 0);
        startXfer(1'b0, 1, 4, 'h100);
        readBurst(1, 4, 'h100, 0);
        reportTest("start while busy", errs);
    endtask

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        write     = 1'b0;
        bankId    = '0;
        len       = '0;
        addr      = '0;
        strobe    = 1'b0;
        wrData    = '0;
        errCount  = 0;
        testCount = 0;
        failCount = 0;
        rngState  = 32'hf65c_5a9e;

        testReset();
        testWriteRead();
        testLineWrap();
        testBanks();
        testBackPressure();
        testIgnoredStart();
        @(negedge clk);

        if (i_cacheStreamTop.i_cacheStreamAsserts.assertFails != 0) begin
            $display("Bound assertions failed %0d times",
                     i_cacheStreamTop.i_cacheStreamAsserts.assertFails);
            errCount++;
        end
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 testCount, failCount, errCount);
        if (errCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog sized from the transfers each test makes
    initial begin
        int limit;
        limit = 10;
        limit = limit + burstCycles(8, 1) + burstCycles(8, 0);
        limit = limit + 5 * burstCycles(8, 0);
        limit = limit + 4 * burstCycles(8, 0);
        limit = limit + burstCycles(16, 0) + burstCycles(16, 8);
        limit = limit + 2 * burstCycles(4, 0) + 2 * burstCycles(6, 0) + 4;
        limit = 2 * limit + 100;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Test failures found");
        $finish;
    end

endmodule
